// File: machv.f
rvIsaPkg.sv
rvPipePkg.sv
rvDecoder.sv
rvRegFile.sv
rvStageReg.sv
rvHazard.sv
rvAlu.sv
rvCore.sv
rvCore_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds and runs the machv testbench under Verilator
# Needs Verilator 5 for --binary and --timing

cd "$(dirname "$0")" || exit 1

objDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module rvCore_tb -Mdir "$objDir" -o simv \
    -f machv.f
buildStatus=$?
if [ "$buildStatus" -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

"./$objDir/simv" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ "$simStatus" -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
fi

if grep -qx "sim passed" "$logFile"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

// File: rvAlu.sv
// Execute stage datapath, combinational
// Operand forwarding, LUI and immediate selects, then the ALU
// Shift amounts use the low 5 bits of operand B
module rvAlu (
    input  rvIsaPkg::wordT    rd1E,
    input  rvIsaPkg::wordT    rd2E,
    input  rvIsaPkg::wordT    immE,
    input  logic              useImm,
    input  logic              isLui,
    input  rvIsaPkg::aluOpT   aluOp,
    input  rvPipePkg::fwdSelT fwdA,
    input  rvPipePkg::fwdSelT fwdB,
    input  rvIsaPkg::wordT    resultM,
    input  rvIsaPkg::wordT    resultW,
    output rvIsaPkg::wordT    result,
    output rvIsaPkg::wordT    storeData
);
    import rvIsaPkg::*;
    import rvPipePkg::*;

    wordT              opA, opB;     // After forwarding
    wordT              srcA, srcB;   // ALU inputs
    logic [shamtW-1:0] shamt;

    function automatic wordT fwdPick(input fwdSelT sel, input wordT regVal,
                                     input wordT memVal, input wordT wbVal);
        wordT val;
        case (sel)
            fwdMem:  val = memVal;
            fwdWb:   val = wbVal;
            default: val = regVal;
        endcase
        return val;
    endfunction

    assign opA = fwdPick(fwdA, rd1E, resultM, resultW);
    assign opB = fwdPick(fwdB, rd2E, resultM, resultW);

    assign srcA  = isLui ? '0 : opA;    // LUI is 0 + imm
    assign srcB  = useImm ? immE : opB;
    assign shamt = srcB[shamtW-1:0];

    assign storeData = opB;  // SW data, already forwarded

    always_comb begin
        case (aluOp)
            aluAdd:  result = srcA + srcB;
            aluSub:  result = srcA - srcB;
            aluAnd:  result = srcA & srcB;
            aluOr:   result = srcA | srcB;
            aluXor:  result = srcA ^ srcB;
            aluSll:  result = srcA << shamt;
            aluSrl:  result = srcA >> shamt;
            aluSra:  result = wordT'($signed(srcA) >>> shamt);
            aluSlt:  result = wordT'($signed(srcA) < $signed(srcB));
            aluSltu: result = wordT'(srcA < srcB);
            default: result = srcA + srcB;
        endcase
    end

endmodule

// File: rvCore.sv
// Five-stage RV32I subset core, in-order, single issue
// Instruction and data ports answer combinationally in the same cycle
// No back-pressure, only stall is the internal load-use case
// memRead is a plain strobe, readData is sampled regardless
module rvCore (
    input  logic           CLK,
    input  logic           rstN,
    input  rvIsaPkg::wordT instr,
    input  rvIsaPkg::wordT readData,
    output rvIsaPkg::wordT pc,
    output rvIsaPkg::wordT addr,
    output rvIsaPkg::wordT writeData,
    output logic           memWrite,
    output logic           memRead
);
    import rvIsaPkg::*;
    import rvPipePkg::*;

    // Stage register images
    fetchDecT fdDin, fdQ;
    decExT    deDin, deQ;
    exMemT    emDin, emQ;
    memWbT    mwDin, mwQ;

    // Decode stage
    regIdxT rs1D, rs2D, rdD;
    aluOpT  aluOpD;
    wordT   immD, rd1D, rd2D;
    logic   useImmD, isLuiD, regWriteD, memToRegD, memWriteD;
    logic   usesRs1D, usesRs2D;

    // Execute and writeback
    wordT   resultE, storeDataE, resultW;
    fwdSelT fwdA, fwdB;
    logic   stallF, stallD, flushE;

    // ==============================
    // Fetch
    // ==============================
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            pc <= pcReset;
        end else if (!stallF) begin
            pc <= pc + 32'd4;  // Straight-line only
        end
    end

    assign fdDin = '{instr: instr};

    rvStageReg #(.payloadT(fetchDecT)) i_regD (
        .CLK(CLK), .rstN(rstN), .stall(stallD), .flush(1'b0),
        .din(fdDin), .bubble(fetchDecBubble), .dout(fdQ)
    );

    // ==============================
    // Decode
    // ==============================
    rvDecoder i_decoder (
        .instr(fdQ.instr), .rs1(rs1D), .rs2(rs2D), .rd(rdD), .aluOp(aluOpD),
        .imm(immD), .useImm(useImmD), .isLui(isLuiD), .regWrite(regWriteD),
        .memToReg(memToRegD), .memWrite(memWriteD),
        .usesRs1(usesRs1D), .usesRs2(usesRs2D)
    );

    rvRegFile i_regFile (
        .CLK(CLK), .rstN(rstN), .rs1(rs1D), .rs2(rs2D),
        .rd(mwQ.rd), .wd(resultW), .we(mwQ.regWrite),
        .rd1(rd1D), .rd2(rd2D)  // Bypassed from writeback
    );

    always_comb begin
        deDin.rd1      = rd1D;
        deDin.rd2      = rd2D;
        deDin.imm      = immD;
        deDin.rs1      = rs1D;
        deDin.rs2      = rs2D;
        deDin.rd       = rdD;
        deDin.aluOp    = aluOpD;
        deDin.useImm   = useImmD;
        deDin.isLui    = isLuiD;
        deDin.regWrite = regWriteD;
        deDin.memToReg = memToRegD;
        deDin.memWrite = memWriteD;
    end

    rvStageReg #(.payloadT(decExT)) i_regE (
        .CLK(CLK), .rstN(rstN), .stall(1'b0), .flush(flushE),
        .din(deDin), .bubble(decExBubble), .dout(deQ)
    );

    // ==============================
    // Execute
    // ==============================
    rvHazard i_hazard (
        .rs1D(rs1D), .rs2D(rs2D), .usesRs1D(usesRs1D), .usesRs2D(usesRs2D),
        .rs1E(deQ.rs1), .rs2E(deQ.rs2), .rdE(deQ.rd), .memToRegE(deQ.memToReg),
        .rdM(emQ.rd), .regWriteM(emQ.regWrite),
        .rdW(mwQ.rd), .regWriteW(mwQ.regWrite),
        .fwdA(fwdA), .fwdB(fwdB),
        .stallF(stallF), .stallD(stallD), .flushE(flushE)
    );

    rvAlu i_alu (
        .rd1E(deQ.rd1), .rd2E(deQ.rd2), .immE(deQ.imm),
        .useImm(deQ.useImm), .isLui(deQ.isLui), .aluOp(deQ.aluOp),
        .fwdA(fwdA), .fwdB(fwdB),
        .resultM(emQ.result), .resultW(resultW),  // Loads never forward from M
        .result(resultE), .storeData(storeDataE)
    );

    assign emDin = '{result: resultE, storeData: storeDataE, rd: deQ.rd,
                     regWrite: deQ.regWrite, memToReg: deQ.memToReg,
                     memWrite: deQ.memWrite};

    rvStageReg #(.payloadT(exMemT)) i_regM (
        .CLK(CLK), .rstN(rstN), .stall(1'b0), .flush(1'b0),
        .din(emDin), .bubble(exMemBubble), .dout(emQ)
    );

    // ==============================
    // Memory and writeback
    // ==============================
    assign addr      = emQ.result;
    assign writeData = emQ.storeData;
    assign memWrite  = emQ.memWrite;
    assign memRead   = emQ.memToReg;

    assign mwDin = '{result: emQ.result, loadData: readData, rd: emQ.rd,
                     regWrite: emQ.regWrite, memToReg: emQ.memToReg};

    rvStageReg #(.payloadT(memWbT)) i_regW (
        .CLK(CLK), .rstN(rstN), .stall(1'b0), .flush(1'b0),
        .din(mwDin), .bubble(memWbBubble), .dout(mwQ)
    );

    assign resultW = mwQ.memToReg ? mwQ.loadData : mwQ.result;

    // Bubble behind a load clears the hazard, so stalls never chain
    assert property (@(posedge CLK) disable iff (!rstN) stallF |=> !stallF)
        else $error("core: load-use stall longer than one cycle");

endmodule

// File: rvCore_tb.sv
// Random-program testbench for the rvCore pipeline
// ROM and data RAM answer combinationally, driven 1 unit after each rising edge
// Loads and stores use base x0 inside a 64-word data region at address 0
// Expected stores, load addresses and load-use stalls come from an ISA model
module rvCore_tb;
    import rvIsaPkg::*;

    localparam int   progLen   = 200;
    localparam int   dataWords = 64;
    localparam int   maxCycles = 2 * progLen + 40;
    localparam wordT drainPc   = pcReset + 4 * (progLen + 4);  // Last instr past memory

    logic CLK, rstN;
    wordT instr, readData, pc, addr, writeData;
    logic memWrite, memRead;

    wordT   prog [progLen];
    wordT   dataMem [dataWords];   // Seen by the DUT
    wordT   modelMem [dataWords];  // ISA model copy
    wordT   storeAddrQ [$];
    wordT   storeDataQ [$];
    wordT   loadAddrQ [$];
    regIdxT lastRd [2];            // Two most recent destinations
    wordT   prevPc;
    int     loadUseCount, holdCount, cycles;
    logic   done;

    rvCore i_dut (
        .CLK(CLK), .rstN(rstN), .instr(instr), .readData(readData), .pc(pc),
        .addr(addr), .writeData(writeData), .memWrite(memWrite), .memRead(memRead)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // ==============================
    // Reporting
    // ==============================
    task automatic failRun(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkEq(input string name, input wordT got, input wordT exp);
        if (got !== exp) begin
            failRun($sformatf("CHECK FAILED t=%0t %s: got %h, expected %h",
                              $time, name, got, exp));
        end
    endtask

    // ==============================
    // Program and reference model
    // ==============================
    function automatic wordT fillWord(input int idx);
        return 32'hc0de0000 ^ (wordT'(idx) * 32'h01000193);  // Whole index mixes in
    endfunction

    // Bias toward recent results so forwarding gets used
    function automatic regIdxT pickReg();
        int roll;
        roll = int'($urandom_range(0, 9));
        if (roll < 3) return lastRd[0];
        if (roll < 5) return lastRd[1];
        return regIdxT'($urandom_range(0, 31));
    endfunction

    task automatic buildProgram();
        int          kind;
        regIdxT      rd, rs1, rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        for (int i = 0; i < progLen; i++) begin
            kind = int'($urandom_range(0, 9));
            rd   = pickReg();
            rs1  = pickReg();
            rs2  = pickReg();
            f3   = 3'($urandom_range(0, 7));
            imm  = 12'($urandom);
            f7   = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1) == 1) ? f7Alt : 7'b0;
            case (kind)
                0, 1, 2: prog[i] = {f7, rs2, rs1, f3, rd, opcR};
                3, 4: begin
                    if (f3 == 3'd1 || f3 == 3'd5) imm = {f7, rs2};  // Shamt form
                    prog[i] = {imm, rs1, f3, rd, opcI};
                end
                5: prog[i] = {20'($urandom), rd, opcLui};
                6, 7: begin
                    imm     = {4'b0, 6'($urandom_range(0, dataWords - 1)), 2'b00};
                    prog[i] = {imm, 5'd0, f3Word, rd, opcLoad};
                end
                default: begin
                    imm     = {4'b0, 6'($urandom_range(0, dataWords - 1)), 2'b00};
                    prog[i] = {imm[11:5], rs2, 5'd0, f3Word, imm[4:0], opcStore};
                end
            endcase
            if (kind < 8) begin  // Stores have no destination
                lastRd[1] = lastRd[0];
                lastRd[0] = rd;
            end
        end
    endtask

    function automatic wordT aluRef(input logic [2:0] f3, input logic alt,
                                    input wordT a, input wordT b);
        wordT r;
        case (f3)
            3'd0:    r = alt ? a - b : a + b;
            3'd1:    r = a << b[4:0];
            3'd2:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    r = (a < b) ? 32'd1 : 32'd0;
            3'd4:    r = a ^ b;
            3'd5:    r = alt ? wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    task automatic runModel();
        wordT       xr [32];
        wordT       ins, a, b, res, ea;
        regIdxT     rd, rs1, rs2, prevRd;
        logic [6:0] opc;
        logic [2:0] f3;
        logic       wr, prevLoad, use1, use2;
        for (int r = 0; r < 32; r++) xr[r] = '0;
        prevLoad = 1'b0;
        prevRd   = '0;
        for (int i = 0; i < progLen; i++) begin
            ins  = prog[i];
            opc  = ins[6:0];
            rd   = ins[11:7];
            f3   = ins[14:12];
            rs1  = ins[19:15];
            rs2  = ins[24:20];
            a    = xr[rs1];
            b    = xr[rs2];
            use1 = (opc != opcLui);  // Every other kept opcode reads rs1
            use2 = (opc == opcR || opc == opcStore);
            if (prevLoad && prevRd != '0 &&
                ((use1 && rs1 == prevRd) || (use2 && rs2 == prevRd))) loadUseCount++;
            wr  = 1'b1;
            res = '0;
            case (opc)
                opcR:   res = aluRef(f3, ins[30], a, b);
                opcI:   res = aluRef(f3, f3 == 3'd5 && ins[30], a,
                                     {{20{ins[31]}}, ins[31:20]});
                opcLui: res = {ins[31:12], 12'h000};
                opcLoad: begin
                    ea  = a + {{20{ins[31]}}, ins[31:20]};
                    res = modelMem[ea[7:2]];
                    loadAddrQ.push_back(ea);
                end
                default: begin  // SW
                    wr = 1'b0;
                    ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    modelMem[ea[7:2]] = b;
                    storeAddrQ.push_back(ea);
                    storeDataQ.push_back(b);
                end
            endcase
            if (wr && rd != '0) xr[rd] = res;  // x0 stays zero
            prevLoad = (opc == opcLoad);
            prevRd   = rd;
        end
    endtask

    // ==============================
    // Per-cycle bus service
    // ==============================
    function automatic wordT fetchWord(input wordT pcVal);
        int idx;
        idx = int'((pcVal - pcReset) >> 2);
        if (pcVal >= pcReset && idx < progLen) return prog[idx];
        return nopInstr;  // Past the program
    endfunction

    task automatic serveCycle();
        if (pc == prevPc) holdCount++;  // Load-use stall
        else checkEq("pc", pc, prevPc + 32'd4);
        prevPc = pc;
        if (memWrite) begin
            if (storeAddrQ.size() == 0) failRun("memWrite pulse after the model's last store");
            checkEq("addr", addr, storeAddrQ.pop_front());
            checkEq("writeData", writeData, storeDataQ.pop_front());
            dataMem[addr[7:2]] = writeData;
        end
        if (memRead) begin
            if (loadAddrQ.size() == 0) failRun("memRead pulse after the model's last load");
            checkEq("addr", addr, loadAddrQ.pop_front());
        end
        instr    = fetchWord(pc);     // Same-cycle ROM answer
        readData = dataMem[addr[7:2]];
        done     = storeAddrQ.size() == 0 && loadAddrQ.size() == 0 && pc >= drainPc;
    endtask

    initial begin
        void'($urandom(32'h5c30));
        rstN         = 1'b0;
        instr        = nopInstr;
        readData     = '0;
        lastRd[0]    = 5'd1;
        lastRd[1]    = 5'd2;
        loadUseCount = 0;
        holdCount    = 0;
        cycles       = 0;
        done         = 1'b0;
        for (int i = 0; i < dataWords; i++) begin
            dataMem[i]  = fillWord(i);
            modelMem[i] = fillWord(i);
        end
        buildProgram();
        runModel();
        repeat (4) begin
            @(posedge CLK);
            #1;
            instr = fetchWord(pc);
        end
        rstN = 1'b1;
        checkEq("pc", pc, pcReset);
        checkEq("memWrite", wordT'(memWrite), '0);
        checkEq("memRead", wordT'(memRead), '0);
        prevPc = pc;
        while (!done) begin
            @(posedge CLK);
            #1;
            cycles++;
            if (cycles > maxCycles) begin
                failRun($sformatf("Timeout: program not finished after %0d cycles", maxCycles));
            end
            serveCycle();
        end
        checkEq("pc hold cycles", wordT'(holdCount), wordT'(loadUseCount));
        $display("sim passed");
        $finish;
    end

endmodule

// File: rvDecoder.sv
// Combinational decode for the kept RV32I subset
// Unknown opcodes and non-word loads/stores decode as a nop
// Register fields pass through raw, usesRs1/usesRs2 tell if they matter
module rvDecoder (
    input  rvIsaPkg::wordT   instr,
    output rvIsaPkg::regIdxT rs1,
    output rvIsaPkg::regIdxT rs2,
    output rvIsaPkg::regIdxT rd,
    output rvIsaPkg::aluOpT  aluOp,
    output rvIsaPkg::wordT   imm,
    output logic             useImm,
    output logic             isLui,
    output logic             regWrite,
    output logic             memToReg,
    output logic             memWrite,
    output logic             usesRs1,
    output logic             usesRs2
);
    import rvIsaPkg::*;

    opcodeT opcode;
    funct3T funct3;
    funct7T funct7;
    wordT   immI, immS, immU;

    // Field split
    assign opcode = instr[opcodeW-1:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    // Immediate formats
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immU = {instr[31:12], 12'b0};

    // Shared by R and I arithmetic, SUB only exists in R form
    function automatic aluOpT aluFromFunct(input funct3T f3, input logic alt,
                                           input logic isReg);
        aluOpT op;
        case (f3)
            f3AddSub: op = (isReg && alt) ? aluSub : aluAdd;
            f3Sll:    op = aluSll;
            f3Slt:    op = aluSlt;
            f3Sltu:   op = aluSltu;
            f3Xor:    op = aluXor;
            f3Sr:     op = alt ? aluSra : aluSrl;
            f3Or:     op = aluOr;
            f3And:    op = aluAnd;
            default:  op = aluAdd;
        endcase
        return op;
    endfunction

    always_comb begin
        // Nop defaults
        aluOp    = aluAdd;
        imm      = '0;
        useImm   = 1'b0;
        isLui    = 1'b0;
        regWrite = 1'b0;
        memToReg = 1'b0;
        memWrite = 1'b0;
        usesRs1  = 1'b0;
        usesRs2  = 1'b0;
        case (opcode)
            opcR: begin
                aluOp    = aluFromFunct(funct3, funct7 == f7Alt, 1'b1);
                regWrite = 1'b1;
                usesRs1  = 1'b1;
                usesRs2  = 1'b1;
            end
            opcI: begin
                aluOp    = aluFromFunct(funct3, funct7 == f7Alt, 1'b0);
                imm      = immI;
                useImm   = 1'b1;
                regWrite = 1'b1;
                usesRs1  = 1'b1;
            end
            opcLui: begin
                imm      = immU;  // 0 + imm
                useImm   = 1'b1;
                isLui    = 1'b1;
                regWrite = 1'b1;
            end
            opcLoad: if (funct3 == f3Word) begin
                imm      = immI;  // Address = rs1 + imm
                useImm   = 1'b1;
                regWrite = 1'b1;
                memToReg = 1'b1;
                usesRs1  = 1'b1;
            end
            opcStore: if (funct3 == f3Word) begin
                imm      = immS;
                useImm   = 1'b1;
                memWrite = 1'b1;
                usesRs1  = 1'b1;
                usesRs2  = 1'b1;  // Store data
            end
            default: ;  // Stays a nop
        endcase
    end

endmodule

// File: rvHazard.sv
// Forwarding selects and load-use detection, combinational
// Memory stage wins over writeback, x0 never forwarded
// Load-use costs one stall cycle, the load then forwards from writeback
module rvHazard (
    input  rvIsaPkg::regIdxT  rs1D,
    input  rvIsaPkg::regIdxT  rs2D,
    input  logic              usesRs1D,
    input  logic              usesRs2D,
    input  rvIsaPkg::regIdxT  rs1E,
    input  rvIsaPkg::regIdxT  rs2E,
    input  rvIsaPkg::regIdxT  rdE,
    input  logic              memToRegE,
    input  rvIsaPkg::regIdxT  rdM,
    input  logic              regWriteM,
    input  rvIsaPkg::regIdxT  rdW,
    input  logic              regWriteW,
    output rvPipePkg::fwdSelT fwdA,
    output rvPipePkg::fwdSelT fwdB,
    output logic              stallF,
    output logic              stallD,
    output logic              flushE
);
    import rvIsaPkg::*;
    import rvPipePkg::*;

    logic hitRs1, hitRs2, loadUse;

    // ==============================
    // Forwarding into execute
    // ==============================
    function automatic fwdSelT pickSrc(input regIdxT src,
                                       input regIdxT rdMem, input logic wrMem,
                                       input regIdxT rdWb, input logic wrWb);
        fwdSelT sel;
        if (wrMem && rdMem != '0 && rdMem == src) begin
            sel = fwdMem;  // Youngest result
        end else if (wrWb && rdWb != '0 && rdWb == src) begin
            sel = fwdWb;
        end else begin
            sel = fwdNone;
        end
        return sel;
    endfunction

    assign fwdA = pickSrc(rs1E, rdM, regWriteM, rdW, regWriteW);
    assign fwdB = pickSrc(rs2E, rdM, regWriteM, rdW, regWriteW);

    // ==============================
    // Load-use stall
    // ==============================
    // Only real source reads count, I-type rs2 field is immediate bits
    assign hitRs1  = usesRs1D && (rs1D == rdE);
    assign hitRs2  = usesRs2D && (rs2D == rdE);
    assign loadUse = memToRegE && (rdE != '0) && (hitRs1 || hitRs2);

    assign stallF = loadUse;  // Hold PC
    assign stallD = loadUse;  // Hold decode register
    assign flushE = loadUse;  // Bubble into execute

endmodule

// File: rvIsaPkg.sv
// RV32I subset encodings shared across the core
// Word-only loads and stores, no branches, no M extension
// Reset vector is fixed at 32'h00400000
package rvIsaPkg;

    // ==============================
    // Widths and base types
    // ==============================
    localparam int xlen     = 32;
    localparam int regAddrW = 5;
    localparam int shamtW   = 5;    // log2 of xlen
    localparam int opcodeW  = 7;
    localparam int funct3W  = 3;
    localparam int funct7W  = 7;

    typedef logic [xlen-1:0]     wordT;
    typedef logic [regAddrW-1:0] regIdxT;
    typedef logic [opcodeW-1:0]  opcodeT;
    typedef logic [funct3W-1:0]  funct3T;
    typedef logic [funct7W-1:0]  funct7T;

    // Major opcodes kept
    localparam opcodeT opcR     = 7'b0110011;
    localparam opcodeT opcI     = 7'b0010011;
    localparam opcodeT opcLui   = 7'b0110111;
    localparam opcodeT opcLoad  = 7'b0000011;
    localparam opcodeT opcStore = 7'b0100011;

    // funct3 for arithmetic
    localparam funct3T f3AddSub = 3'b000;
    localparam funct3T f3Sll    = 3'b001;
    localparam funct3T f3Slt    = 3'b010;
    localparam funct3T f3Sltu   = 3'b011;
    localparam funct3T f3Xor    = 3'b100;
    localparam funct3T f3Sr     = 3'b101;
    localparam funct3T f3Or     = 3'b110;
    localparam funct3T f3And    = 3'b111;
    localparam funct3T f3Word   = 3'b010;  // LW / SW width
    localparam funct7T f7Alt    = 7'b0100000;  // SUB, SRA, SRAI

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor,
        aluSll, aluSrl, aluSra, aluSlt, aluSltu
    } aluOpT;

    localparam wordT nopInstr = 32'h00000013;  // ADDI x0,x0,0
    localparam wordT pcReset  = 32'h00400000;

endpackage

// File: rvPipePkg.sv
// Stage payloads for the five-stage pipeline
// Each struct is a stage-register image, loaded as a whole
// Bubbles carry no writes and no memory access
package rvPipePkg;

    // Fetch to decode
    typedef struct packed {
        rvIsaPkg::wordT instr;
    } fetchDecT;

    // Decode to execute
    typedef struct packed {
        rvIsaPkg::wordT   rd1;       // Register file values, bypassed
        rvIsaPkg::wordT   rd2;
        rvIsaPkg::wordT   imm;
        rvIsaPkg::regIdxT rs1;       // Kept for forwarding compares
        rvIsaPkg::regIdxT rs2;
        rvIsaPkg::regIdxT rd;
        rvIsaPkg::aluOpT  aluOp;
        logic             useImm;
        logic             isLui;
        logic             regWrite;
        logic             memToReg;  // Load
        logic             memWrite;  // Store
    } decExT;

    // Execute to memory
    typedef struct packed {
        rvIsaPkg::wordT   result;     // ALU result or address
        rvIsaPkg::wordT   storeData;
        rvIsaPkg::regIdxT rd;
        logic             regWrite;
        logic             memToReg;
        logic             memWrite;
    } exMemT;

    // Memory to writeback
    typedef struct packed {
        rvIsaPkg::wordT   result;
        rvIsaPkg::wordT   loadData;
        rvIsaPkg::regIdxT rd;
        logic             regWrite;
        logic             memToReg;
    } memWbT;

    typedef enum logic [1:0] {fwdNone, fwdMem, fwdWb} fwdSelT;

    // ==============================
    // Bubble images
    // ==============================
    localparam fetchDecT fetchDecBubble = '{instr: rvIsaPkg::nopInstr};
    localparam decExT    decExBubble    = '0;
    localparam exMemT    exMemBubble    = '0;
    localparam memWbT    memWbBubble    = '0;

endpackage

// File: rvRegFile.sv
// 32 x 32 register file, x0 hard-wired to zero
// Writes on the clock edge, reads combinational
// A read of the register being written returns the new value
module rvRegFile (
    input  logic             CLK,
    input  logic             rstN,
    input  rvIsaPkg::regIdxT rs1,
    input  rvIsaPkg::regIdxT rs2,
    input  rvIsaPkg::regIdxT rd,
    input  rvIsaPkg::wordT   wd,
    input  logic             we,
    output rvIsaPkg::wordT   rd1,
    output rvIsaPkg::wordT   rd2
);
    import rvIsaPkg::*;

    wordT regs [1:(2**regAddrW)-1];  // No storage for x0

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 2**regAddrW; i++) regs[i] <= '0;
        end else if (we && rd != '0) begin
            regs[rd] <= wd;
        end
    end

    // Read ports with write-through bypass
    always_comb begin
        rd1 = '0;
        if (rs1 != '0) rd1 = (we && rs1 == rd) ? wd : regs[rs1];
    end

    always_comb begin
        rd2 = '0;
        if (rs2 != '0) rd2 = (we && rs2 == rd) ? wd : regs[rs2];
    end

endmodule

// File: rvStageReg.sv
// Generic pipeline register, one per stage boundary
// Reset and flush load the bubble image, stall holds
// Stall and flush are not expected together
module rvStageReg #(
    parameter type payloadT = rvIsaPkg::wordT
) (
    input  logic    CLK,
    input  logic    rstN,
    input  logic    stall,
    input  logic    flush,
    input  payloadT din,
    input  payloadT bubble,  // Tied to a constant per stage
    output payloadT dout
);

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            dout <= bubble;
        end else if (flush) begin
            dout <= bubble;
        end else if (!stall) begin
            dout <= din;
        end
    end

    assert property (@(posedge CLK) disable iff (!rstN) !(stall && flush))
        else $error("stage register: stall with flush");

endmodule
